/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary -f sim.f --top-module rob_tb -o rob_sim || exit 1

out="$(./obj_dir/rob_sim +verilator+error+limit+100)"
echo "$out"

echo "$out" | grep -qF '** PASS **' && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+src
src/uop_pkg.sv
src/rob_port_pkg.sv
src/rob_alloc.sv
src/rob_entry_bank.sv
src/rob_commit_ctrl.sv
src/rob_top.sv
test/rob_asserts.sv
test/rob_tb.sv

/* src/rob_alloc.sv */
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_alloc (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  logic [`ROB_IDX_W-1:0] head,
    output logic                  dispatch_ready,
    output logic                  pause_req,
    output logic                  rob_empty,
    output logic                  alloc_we,
    output logic [`ROB_IDX_W-1:0] tail
);

    localparam logic [`ROB_IDX_W:0] size_c     = `ROB_SIZE;
    localparam logic [`ROB_IDX_W:0] full_level = size_c - 1'b1;

    logic [`ROB_IDX_W:0] v_head;
    logic [`ROB_IDX_W:0] free_cnt;
    logic [`ROB_IDX_W:0] occupancy;
    logic                full;

    // head is lifted by one lap when the live region does not wrap,
    // so v_head - tail always counts free pairs
    assign v_head    = {tail >= head, head};
    assign free_cnt  = v_head - {1'b0, tail};
    assign occupancy = size_c - free_cnt;

    // one pair is always kept free so head == tail means empty
    assign full      = occupancy >= full_level;
    assign rob_empty = head == tail;

    assign dispatch_ready = !full;
    assign pause_req      = full;
    assign alloc_we       = dispatch_valid && dispatch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (flush) begin
            tail <= '0;
        end else if (alloc_we) begin
            tail <= tail + 1'b1;
        end
    end

endmodule

/* src/rob_commit_ctrl.sv */
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_commit_ctrl
    import uop_pkg::*;
    import rob_port_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  rob_empty,
    input  uop_t                  head_uop0,
    input  uop_t                  head_uop1,
    input  logic                  commit_ready,
    output logic [`ROB_IDX_W-1:0] head,
    output logic                  commit_valid,
    output logic                  commit_mark0,
    output logic                  commit_mark1,
    output commit_bundle_t        commit_bundle
);

    logic clear0;
    logic good0;
    logic good1;
    logic fire;
    logic done0;
    logic done1;

    // slot 0 out of the way already
    assign clear0 = !head_uop0.valid || head_uop0.committed;

    assign good0 = head_uop0.valid && !head_uop0.committed && !head_uop0.busy;

    // slot 1 may only go with slot 0 or after it
    // ready is kept out of this so the bundle holds under back-pressure
    assign good1 = head_uop1.valid && !head_uop1.committed && !head_uop1.busy &&
                   (clear0 || good0);

    assign commit_valid = (good0 || good1) && !rob_empty;
    assign fire         = commit_valid && commit_ready;

    assign commit_mark0 = fire && good0;
    assign commit_mark1 = fire && good1;

    assign commit_bundle.uop0  = head_uop0;
    assign commit_bundle.uop1  = head_uop1;
    assign commit_bundle.take0 = good0;
    assign commit_bundle.take1 = good1;

    // both slots finished with, now or earlier
    assign done0 = clear0 || commit_mark0;
    assign done1 = !head_uop1.valid || head_uop1.committed || commit_mark1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else if (flush) begin
            head <= '0;
        end else if (done0 && done1 && !rob_empty) begin
            head <= head + 1'b1;
        end
    end

endmodule

/* src/rob_entry_bank.sv */
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_entry_bank
    import uop_pkg::*;
    import rob_port_pkg::*;
#(
    parameter int bank_slot = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  alloc_we,
    input  logic [`ROB_IDX_W-1:0] tail,
    input  uop_t                  dispatch_uop,
    input  fu_report_t            alu0_report,
    input  fu_report_t            alu1_report,
    input  fu_report_t            mdu_report,
    input  fu_report_t            lsu_report,
    input  logic [`ROB_IDX_W-1:0] head,
    input  logic                  commit_mark,
    output uop_t                  head_uop
);

    localparam int  num_reports = 4;
    localparam bit  slot_bit    = 1'(bank_slot);

    // report order is alu0, alu1, mdu, lsu
    // only the ALUs carry branch outcomes
    localparam logic [num_reports-1:0] may_branch = 4'b0011;
    // the multiply/divide unit never raises an exception
    localparam logic [num_reports-1:0] may_exc    = 4'b1011;

    uop_t                  entries    [`ROB_SIZE];
    fu_report_t            reports    [num_reports];
    logic [`ROB_IDX_W-1:0] report_idx [num_reports];
    logic                  report_hit [num_reports];

    assign reports[0] = alu0_report;
    assign reports[1] = alu1_report;
    assign reports[2] = mdu_report;
    assign reports[3] = lsu_report;

    // pair index from tag, low bit picks the column
    always_comb begin
        for (int p = 0; p < num_reports; p++) begin
            report_idx[p] = reports[p].tag[`ROB_TAG_W-1:1];
            report_hit[p] = reports[p].finish && (reports[p].tag[0] == slot_bit);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entries <= '{default: '0};
        end else if (flush) begin
            entries <= '{default: '0};
        end else begin
            // new micro-op at the tail, tag assigned here
            if (alloc_we) begin
                entries[tail]           <= dispatch_uop;
                entries[tail].tag       <= {tail, slot_bit};
                entries[tail].committed <= 1'b0;
            end

            // completions, each one for a distinct in-flight tag
            for (int p = 0; p < num_reports; p++) begin
                if (report_hit[p]) begin
                    entries[report_idx[p]].busy <= 1'b0;
                    if (may_branch[p] && reports[p].set_branch) begin
                        entries[report_idx[p]].branch_taken <= reports[p].branch_taken;
                        entries[report_idx[p]].branch_addr  <= reports[p].branch_addr;
                    end
                    if (may_exc[p] && reports[p].set_exc) begin
                        entries[report_idx[p]].cause_exc <= 1'b1;
                        entries[report_idx[p]].exception <= reports[p].exc;
                    end
                end
            end

            // retire marks the head slot so a split pair is not offered twice
            if (commit_mark) begin
                entries[head].committed <= 1'b1;
            end
        end
    end

    assign head_uop = entries[head];

endmodule

/* src/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// reorder buffer geometry

// pair entries held in the buffer
`define ROB_SIZE 16

// pair index width, log2 of ROB_SIZE
`define ROB_IDX_W 4

// per micro-op tag, pair index plus slot bit
`define ROB_TAG_W 5

// address and data path width
`define XLEN 32

`endif

/* src/rob_port_pkg.sv */
`include "rob_params.svh"

package rob_port_pkg;

    // pair delivered by dispatch, one ROB index for both
    typedef struct packed {
        uop_pkg::uop_t uop0;
        uop_pkg::uop_t uop1;
    } dispatch_pair_t;

    // completion strobe from one execution unit
    typedef struct packed {
        logic                  finish;
        logic [`ROB_TAG_W-1:0] tag;
        logic                  set_branch;
        logic                  branch_taken;
        logic [`XLEN-1:0]      branch_addr;
        logic                  set_exc;
        uop_pkg::exc_e         exc;
    } fu_report_t;

    // head pair offered to retire
    // take0/take1 flag the slots retiring on this handshake
    typedef struct packed {
        uop_pkg::uop_t uop0;
        uop_pkg::uop_t uop1;
        logic          take0;
        logic          take1;
    } commit_bundle_t;

endpackage

/* src/rob_top.sv */
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_top
    import uop_pkg::*;
    import rob_port_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,
    input  logic                  dispatch_valid,
    input  dispatch_pair_t        dispatch_pair,
    input  fu_report_t            alu0_report,
    input  fu_report_t            alu1_report,
    input  fu_report_t            mdu_report,
    input  fu_report_t            lsu_report,
    input  logic                  commit_ready,
    output logic                  dispatch_ready,
    output logic [`ROB_IDX_W-1:0] rob_index,
    output logic                  rob_empty,
    output logic                  pause_req,
    output logic                  commit_valid,
    output commit_bundle_t        commit_bundle
);

    logic                  alloc_we;
    logic [`ROB_IDX_W-1:0] head;
    logic [`ROB_IDX_W-1:0] tail;
    logic                  commit_mark0;
    logic                  commit_mark1;
    uop_t                  head_uop0;
    uop_t                  head_uop1;

    // next pair gets the current tail
    assign rob_index = tail;

    rob_alloc alloc_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .head           (head),
        .dispatch_ready (dispatch_ready),
        .pause_req      (pause_req),
        .rob_empty      (rob_empty),
        .alloc_we       (alloc_we),
        .tail           (tail)
    );

    rob_entry_bank #(.bank_slot(0)) bank0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .alloc_we     (alloc_we),
        .tail         (tail),
        .dispatch_uop (dispatch_pair.uop0),
        .alu0_report  (alu0_report),
        .alu1_report  (alu1_report),
        .mdu_report   (mdu_report),
        .lsu_report   (lsu_report),
        .head         (head),
        .commit_mark  (commit_mark0),
        .head_uop     (head_uop0)
    );

    rob_entry_bank #(.bank_slot(1)) bank1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .alloc_we     (alloc_we),
        .tail         (tail),
        .dispatch_uop (dispatch_pair.uop1),
        .alu0_report  (alu0_report),
        .alu1_report  (alu1_report),
        .mdu_report   (mdu_report),
        .lsu_report   (lsu_report),
        .head         (head),
        .commit_mark  (commit_mark1),
        .head_uop     (head_uop1)
    );

    rob_commit_ctrl commit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .rob_empty     (rob_empty),
        .head_uop0     (head_uop0),
        .head_uop1     (head_uop1),
        .commit_ready  (commit_ready),
        .head          (head),
        .commit_valid  (commit_valid),
        .commit_mark0  (commit_mark0),
        .commit_mark1  (commit_mark1),
        .commit_bundle (commit_bundle)
    );

endmodule

/* src/uop_pkg.sv */
`include "rob_params.svh"

package uop_pkg;

    // coarse opcode class, picks the execution unit
    typedef enum logic [2:0] {
        op_alu    = 3'd0,
        op_branch = 3'd1,
        op_mdu    = 3'd2,
        op_load   = 3'd3,
        op_store  = 3'd4
    } op_class_e;

    // recorded exception cause
    typedef enum logic [3:0] {
        exc_none     = 4'd0,
        exc_overflow = 4'd1,
        exc_adel     = 4'd2,
        exc_ades     = 4'd3,
        exc_syscall  = 4'd4,
        exc_break    = 4'd5,
        exc_ri       = 4'd6
    } exc_e;

    // one micro-op as stored in a ROB slot
    typedef struct packed {
        logic                  valid;
        logic                  busy;
        logic                  committed;
        op_class_e             op_class;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      pc;
        logic [4:0]            dest;
        logic                  branch_taken;
        logic [`XLEN-1:0]      branch_addr;
        logic                  cause_exc;
        exc_e                  exception;
    } uop_t;

endpackage

/* test/rob_asserts.sv */
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_asserts
    import uop_pkg::*;
    import rob_port_pkg::*;
(
    input logic           clk,
    input logic           rst_n,
    input logic           flush,
    input logic           commit_ready,
    input logic           commit_valid,
    input commit_bundle_t commit_bundle,
    input logic           dispatch_ready,
    input logic           pause_req,
    input logic           rob_empty
);

    // count of failed properties, watched by the testbench
    int bad_count = 0;

    // idle state right out of reset
    reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        !commit_valid && !pause_req && dispatch_ready && rob_empty)
        else begin bad_count++; $error("outputs wrong after reset"); end

    // pause and ready are two views of full
    pause_vs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pause_req == !dispatch_ready)
        else begin bad_count++; $error("pause_req and dispatch_ready disagree"); end

    // an offered slot stays offered and unchanged while retire stalls
    hold_slot0: assert property (@(posedge clk) disable iff (!rst_n || flush)
        commit_valid && !commit_ready && commit_bundle.take0 |=>
        commit_valid && commit_bundle.take0 && $stable(commit_bundle.uop0))
        else begin bad_count++; $error("slot 0 changed under back-pressure"); end

    hold_slot1: assert property (@(posedge clk) disable iff (!rst_n || flush)
        commit_valid && !commit_ready && commit_bundle.take1 |=>
        commit_valid && commit_bundle.take1 && $stable(commit_bundle.uop1))
        else begin bad_count++; $error("slot 1 changed under back-pressure"); end

    // slot 1 never overtakes slot 0
    slot_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && commit_bundle.take1 |-> commit_bundle.take0 ||
        !commit_bundle.uop0.valid || commit_bundle.uop0.committed)
        else begin bad_count++; $error("slot 1 offered ahead of slot 0"); end

    no_busy_take: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> !(commit_bundle.take0 && commit_bundle.uop0.busy) &&
        !(commit_bundle.take1 && commit_bundle.uop1.busy))
        else begin bad_count++; $error("busy slot offered for retire"); end

    flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> rob_empty && !commit_valid)
        else begin bad_count++; $error("buffer not empty after flush"); end

endmodule

/* test/rob_tb.sv */
`timescale 1ns/1ns
`include "rob_params.svh"

module rob_tb
    import uop_pkg::*;
    import rob_port_pkg::*;
();

    localparam int num_pairs = 240;
    localparam int num_tags  = 2 * `ROB_SIZE;

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic                  dispatch_valid;
    dispatch_pair_t        dispatch_pair;
    fu_report_t            alu0_report;
    fu_report_t            alu1_report;
    fu_report_t            mdu_report;
    fu_report_t            lsu_report;
    logic                  commit_ready;
    logic                  dispatch_ready;
    logic [`ROB_IDX_W-1:0] rob_index;
    logic                  rob_empty;
    logic                  pause_req;
    logic                  commit_valid;
    commit_bundle_t        commit_bundle;

    // expected contents per tag
    logic [`XLEN-1:0]      exp_pc    [num_tags];
    op_class_e             exp_class [num_tags];
    logic [4:0]            exp_dest  [num_tags];
    logic                  exp_taken [num_tags];
    logic [`XLEN-1:0]      exp_baddr [num_tags];
    logic                  exp_cause [num_tags];
    exc_e                  exp_exc   [num_tags];
    // tags still waiting for a unit
    // unit_of holds 0 for alu, 1 for mdu, 2 for lsu
    logic                  pending   [num_tags];
    int                    unit_of   [num_tags];
    logic [`ROB_TAG_W-1:0] order_q   [$];
    // index the next accepted pair should get
    logic [`ROB_IDX_W-1:0] exp_index;

    int pairs_sent;
    int ready_pct;
    bit send_on;
    bit force_send;
    bit withhold;
    bit do_flush;

    rob_top rob_top_inst (.*);

    bind rob_top rob_asserts asserts_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .commit_ready   (commit_ready),
        .commit_valid   (commit_valid),
        .commit_bundle  (commit_bundle),
        .dispatch_ready (dispatch_ready),
        .pause_req      (pause_req),
        .rob_empty      (rob_empty)
    );

    always #2 clk = ~clk;

    initial begin
        #(num_pairs * 200);
        $display("watchdog expired, the test did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

    task automatic fail_now(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    function automatic uop_t make_uop(input logic v);
        uop_t u;
        u              = '0;
        u.valid        = v;
        u.busy         = v;
        u.op_class     = op_class_e'(3'($urandom_range(4)));
        u.pc           = $urandom;
        u.dest         = 5'($urandom);
        u.branch_taken = 1'($urandom);
        u.branch_addr  = $urandom;
        return u;
    endfunction

    task automatic record(input uop_t u, input logic [`ROB_TAG_W-1:0] t);
        exp_pc[t]    = u.pc;
        exp_class[t] = u.op_class;
        exp_dest[t]  = u.dest;
        exp_taken[t] = u.branch_taken;
        exp_baddr[t] = u.branch_addr;
        exp_cause[t] = 1'b0;
        exp_exc[t]   = exc_none;
        pending[t]   = 1'b1;
        if (u.op_class == op_mdu) begin
            unit_of[t] = 1;
        end else if (u.op_class == op_load || u.op_class == op_store) begin
            unit_of[t] = 2;
        end else begin
            unit_of[t] = 0;
        end
        order_q.push_back(t);
    endtask

    task automatic check_retire(input uop_t u);
        logic [`ROB_TAG_W-1:0] t;
        if (order_q.size() == 0) begin
            fail_now($sformatf("tag %0d retired with nothing outstanding", u.tag));
        end else begin
            t = order_q.pop_front();
            assert (u.tag == t) else fail_now($sformatf("retired tag %0d, expected %0d", u.tag, t));
            assert (!u.busy) else fail_now($sformatf("tag %0d retired while busy", t));
            assert (u.pc == exp_pc[t] && u.op_class == exp_class[t])
                else fail_now($sformatf("tag %0d pc or class wrong", t));
            assert (u.dest == exp_dest[t])
                else fail_now($sformatf("tag %0d dest wrong", t));
            assert (u.branch_taken == exp_taken[t] && u.branch_addr == exp_baddr[t])
                else fail_now($sformatf("tag %0d branch outcome wrong", t));
            assert (u.cause_exc == exp_cause[t] && u.exception == exp_exc[t])
                else fail_now($sformatf("tag %0d exception wrong", t));
        end
    endtask

    // sample at the falling edge what the next rising edge will do
    task automatic observe();
        fu_report_t            r [4];
        logic [`ROB_TAG_W-1:0] base;
        r = '{alu0_report, alu1_report, mdu_report, lsu_report};
        assert (rob_top_inst.asserts_inst.bad_count == 0)
            else fail_now("a concurrent assertion failed");
        assert (rob_index == exp_index)
            else fail_now($sformatf("rob_index %0d, expected %0d", rob_index, exp_index));
        if (flush) begin
            order_q.delete();
            pending   = '{default: 1'b0};
            exp_index = '0;
        end else begin
            for (int p = 0; p < 4; p++) begin
                if (r[p].finish && r[p].set_branch) begin
                    exp_taken[r[p].tag] = r[p].branch_taken;
                    exp_baddr[r[p].tag] = r[p].branch_addr;
                end
                if (r[p].finish && r[p].set_exc) begin
                    exp_cause[r[p].tag] = 1'b1;
                    exp_exc[r[p].tag]   = r[p].exc;
                end
            end
            if (commit_valid && commit_ready) begin
                if (commit_bundle.take0) check_retire(commit_bundle.uop0);
                if (commit_bundle.take1) check_retire(commit_bundle.uop1);
            end
            if (dispatch_valid && dispatch_ready) begin
                base = {exp_index, 1'b0};
                record(dispatch_pair.uop0, base);
                if (dispatch_pair.uop1.valid) record(dispatch_pair.uop1, base | 1'b1);
                exp_index = exp_index + 1'b1;
                pairs_sent++;
            end
        end
    endtask

    // a random waiting tag per unit gives out-of-order finishes
    task automatic finish_one(input int unit, input bit br, input bit ex,
                              output fu_report_t r);
        logic [`ROB_TAG_W-1:0] cand [$];
        logic [`ROB_TAG_W-1:0] t;
        r = '0;
        for (int i = 0; i < num_tags; i++) begin
            if (pending[i] && unit_of[i] == unit) cand.push_back(5'(i));
        end
        if (!withhold && cand.size() > 0 && $urandom_range(2) == 0) begin
            t              = cand[$urandom_range(cand.size() - 1)];
            pending[t]     = 1'b0;
            r.finish       = 1'b1;
            r.tag          = t;
            r.set_branch   = br && ($urandom_range(1) == 0);
            r.branch_taken = 1'($urandom);
            r.branch_addr  = $urandom;
            r.set_exc      = ex && ($urandom_range(3) == 0);
            r.exc          = exc_e'(4'($urandom_range(6, 1)));
        end
    endtask

    task automatic drive();
        flush          = do_flush;
        do_flush       = 1'b0;
        commit_ready   = ($urandom_range(99) < ready_pct);
        dispatch_valid = send_on && (force_send || $urandom_range(3) != 0);
        dispatch_pair.uop0 = make_uop(1'b1);
        dispatch_pair.uop1 = make_uop($urandom_range(3) != 0);
        finish_one(0, 1'b1, 1'b1, alu0_report);
        finish_one(0, 1'b1, 1'b1, alu1_report);
        finish_one(1, 1'b0, 1'b0, mdu_report);
        finish_one(2, 1'b0, 1'b1, lsu_report);
    endtask

    task automatic cycle();
        @(negedge clk);
        observe();
        @(posedge clk);
        #1;
        drive();
    endtask

    task automatic drain();
        send_on   = 1'b0;
        withhold  = 1'b0;
        ready_pct = 100;
        while (order_q.size() > 0) cycle();
        repeat (2) cycle();
    endtask

    initial begin
        int                    start;
        logic [`ROB_IDX_W-1:0] held_index;
        void'($urandom(6));
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_pair = '0;
        alu0_report = '0;
        alu1_report = '0;
        mdu_report = '0;
        lsu_report = '0;
        commit_ready = 1'b0;
        pending = '{default: 1'b0};
        exp_index = '0;
        pairs_sent = 0;
        ready_pct = 60;
        send_on = 1'b0;
        force_send = 1'b0;
        withhold = 1'b0;
        do_flush = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!commit_valid && !pause_req && dispatch_ready && rob_empty)
            else fail_now("outputs not idle after reset");

        // random traffic with back-pressure
        send_on = 1'b1;
        while (pairs_sent < 200) cycle();
        drain();

        // fill with completions held back
        withhold = 1'b1;
        send_on  = 1'b1;
        start    = pairs_sent;
        while (dispatch_ready) cycle();
        assert (pairs_sent - start == `ROB_SIZE - 1 && pause_req)
            else fail_now($sformatf("full after %0d pairs", pairs_sent - start));
        force_send = 1'b1;
        held_index = rob_index;
        repeat (5) cycle();
        assert (pairs_sent - start == `ROB_SIZE - 1 && rob_index == held_index)
            else fail_now("pair accepted while full");
        force_send = 1'b0;
        drain();

        // flush drops everything in flight
        withhold = 1'b1;
        send_on  = 1'b1;
        repeat (6) cycle();
        send_on  = 1'b0;
        do_flush = 1'b1;
        repeat (2) cycle();
        assert (rob_empty && !commit_valid) else fail_now("buffer not cleared by flush");
        withhold = 1'b0;
        send_on  = 1'b1;
        start    = pairs_sent;
        while (pairs_sent - start < 20) cycle();
        drain();

        @(negedge clk);
        if (rob_top_inst.asserts_inst.bad_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            fail_now("a concurrent assertion failed");
        end
    end

endmodule
